// ==== Bender.yml ====
package:
  name: rcc_lite

dependencies: {}

sources:
  # package first, then leaf blocks up to the top level
  - hw/rcc_pkg.sv
  - hw/rcc_reset_sync.sv
  - hw/rcc_rst_sync.sv
  - hw/rcc_periph_rst.sv
  - hw/rcc_sys_clk_ctrl.sv
  - hw/rcc_regs.sv
  - hw/rcc_top.sv

  - target: test
    files:
      - tests/rcc_tb.sv

// ==== filelist.f ====
hw/rcc_pkg.sv
hw/rcc_reset_sync.sv
hw/rcc_rst_sync.sv
hw/rcc_periph_rst.sv
hw/rcc_sys_clk_ctrl.sv
hw/rcc_regs.sv
hw/rcc_top.sv
tests/rcc_tb.sv

// ==== hw/rcc_periph_rst.sv ====
// peripheral reset generator on per_clk
// software hold bits synchronized, each reset stretched to a minimum length

`timescale 1ns/100ps

module rcc_periph_rst (
  input  logic                  per_clk,
  input  logic                  per_sync_rst_n,
  input  rcc_pkg::periph_mask_t sw_rst,
  output rcc_pkg::periph_mask_t per_rst_n
);

  import rcc_pkg::*;

  periph_mask_t           rst_meta;
  periph_mask_t           rst_sync;
  logic [PULSE_CNT_W-1:0] pulse_cnt [NUM_PERIPH];

  // two-flop crossing from sys_clk
  always_ff @(posedge per_clk) begin
    if (!per_sync_rst_n) begin
      rst_meta <= '0;
      rst_sync <= '0;
    end else begin
      rst_meta <= sw_rst;
      rst_sync <= rst_meta;
    end
  end

  // counter reloads while the bit is held, output rises once it runs out
  always_ff @(posedge per_clk) begin
    if (!per_sync_rst_n) begin
      per_rst_n <= '0;
      for (int i = 0; i < NUM_PERIPH; i++) begin
        pulse_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PERIPH; i++) begin
        if (rst_sync[i]) begin
          per_rst_n[i] <= 1'b0;
          pulse_cnt[i] <= PULSE_CNT_W'(RST_PULSE_CYCLES - 1);
        end else if (!per_rst_n[i]) begin
          if (pulse_cnt[i] != '0) begin
            pulse_cnt[i] <= pulse_cnt[i] - 1'b1;
          end else begin
            per_rst_n[i] <= 1'b1;
          end
        end
      end
    end
  end

  for (genvar g = 0; g < NUM_PERIPH; g++) begin : g_min_pulse
    a_min_low: assert property (
      @(posedge per_clk) disable iff (!per_sync_rst_n)
      $fell(per_rst_n[g]) |-> !per_rst_n[g] [*RST_PULSE_CYCLES]
    ) else $error("per_rst_n[%0d] low for less than the minimum", g);
  end

endmodule

// ==== hw/rcc_pkg.sv ====
// shared constants for the reset and clock control block
// vector types for register access and peripheral masks
// clock source and switch FSM encodings

package rcc_pkg;

  // **********************************************************************
  // sizing
  // **********************************************************************
  localparam int RST_SYNC_STAGES  = 2;
  localparam int NUM_PERIPH       = 4;
  localparam int RST_PULSE_CYCLES = 8;
  localparam int SWITCH_TIMEOUT   = 16;

  // counter widths derived from the limits above
  localparam int PULSE_CNT_W = $clog2(RST_PULSE_CYCLES);
  localparam int TMO_CNT_W   = $clog2(SWITCH_TIMEOUT);

  // **********************************************************************
  // register access
  // **********************************************************************
  typedef logic [1:0]            rcc_addr_t;
  typedef logic [7:0]            rcc_data_t;
  typedef logic [NUM_PERIPH-1:0] periph_mask_t;

  // register map
  localparam rcc_addr_t ADDR_CFGR = 2'd0;
  localparam rcc_addr_t ADDR_RSTR = 2'd1;
  localparam rcc_addr_t ADDR_SR   = 2'd2;

  // **********************************************************************
  // clock selection
  // **********************************************************************
  typedef enum logic [1:0] {
    HSI  = 2'd0,
    HSE  = 2'd1,
    PLL1 = 2'd2,
    CSI  = 2'd3
  } sysclk_src_t;

  typedef enum logic [1:0] {
    RUN      = 2'd0,
    WAIT_RDY = 2'd1,
    SWITCH   = 2'd2,
    CSS_HOLD = 2'd3
  } sw_state_t;

endpackage

// ==== hw/rcc_regs.sv ====
// register bank on sys_clk with strobe access
// CFGR clock select, RSTR peripheral reset hold, SR sticky flags
// switch request pulse and flag capture from controller events

`timescale 1ns/100ps

module rcc_regs (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  // register access
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  rcc_pkg::rcc_addr_t    addr,
  input  rcc_pkg::rcc_data_t    wdata,
  output rcc_pkg::rcc_data_t    rdata,
  // clock controller side
  input  rcc_pkg::sysclk_src_t  sysclk_sws,
  input  logic                  css_evt,
  input  logic                  sw_err_evt,
  output logic                  sw_req,
  output rcc_pkg::sysclk_src_t  sw_src,
  output logic                  css_flag,
  // peripheral reset side
  output rcc_pkg::periph_mask_t sw_rst
);

  import rcc_pkg::*;

  logic      wr_cfgr;
  logic      wr_rstr;
  logic      wr_sr;
  logic      sw_err;
  rcc_data_t rd_mux;

  assign wr_cfgr = wr_en && (addr == ADDR_CFGR);
  assign wr_rstr = wr_en && (addr == ADDR_RSTR);
  assign wr_sr   = wr_en && (addr == ADDR_SR);

  // **********************************************************************
  // CFGR and RSTR
  // **********************************************************************
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      sw_src <= HSI;
      sw_req <= 1'b0;
      sw_rst <= '0;
    end else begin
      // request pulses on every CFGR write, even to the current source
      sw_req <= wr_cfgr;
      if (wr_cfgr) begin
        sw_src <= sysclk_src_t'(wdata[1:0]);
      end
      if (wr_rstr) begin
        sw_rst <= wdata[NUM_PERIPH-1:0];
      end
    end
  end

  // **********************************************************************
  // SR flags
  // **********************************************************************
  // write 1 to clear, a new event in the same cycle keeps the flag set
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      css_flag <= 1'b0;
      sw_err   <= 1'b0;
    end else begin
      css_flag <= (css_flag && !(wr_sr && wdata[0])) || css_evt;
      sw_err   <= (sw_err && !(wr_sr && wdata[1])) || sw_err_evt;
    end
  end

  // read path
  always_comb begin
    case (addr)
      ADDR_CFGR: rd_mux = {4'b0000, sysclk_sws, sw_src};
      ADDR_RSTR: rd_mux = rcc_data_t'(sw_rst);
      ADDR_SR:   rd_mux = {6'b000000, sw_err, css_flag};
      default:   rd_mux = '0;
    endcase
  end

  // read data held until the next read strobe
  always_ff @(posedge sys_clk) begin
    if (rd_en) begin
      rdata <= rd_mux;
    end
  end

endmodule

// ==== hw/rcc_reset_sync.sv ====
// single reset synchronizer
// asserts with the source reset, releases through a flop chain on clk

`timescale 1ns/100ps

module rcc_reset_sync (
  input  logic clk,
  input  logic src_rst_n,
  output logic gen_rst_n
);

  import rcc_pkg::*;

  logic [RST_SYNC_STAGES-1:0] sync_chain;

  // chain clears at once, then fills with ones one stage per edge
  always_ff @(posedge clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      sync_chain <= '0;
    end else begin
      sync_chain <= {sync_chain[RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign gen_rst_n = sync_chain[RST_SYNC_STAGES-1];

  // release only after the source has been high for a full edge
  a_no_early_release: assert property (
    @(posedge clk) $rose(gen_rst_n) |-> src_rst_n && $past(src_rst_n)
  ) else $error("gen_rst_n released while src_rst_n was low");

endmodule

// ==== hw/rcc_rst_sync.sv ====
// reset synchronizer bank
// one release synchronizer per kernel clock domain
// clock security failure turned into an active-high sys_clk reset

`timescale 1ns/100ps

module rcc_rst_sync (
  // clocks
  input  logic sys_clk,
  input  logic pll1_p_clk,
  input  logic pll1_q_clk,
  input  logic pll2_p_clk,
  input  logic hse_origin_clk,
  input  logic hsi_origin_clk,
  input  logic lsi_clk,
  input  logic per_clk,
  // reset sources
  input  logic sys_rst_n,
  input  logic hsecss_fail,
  // synced resets
  output logic css_fail_rst,
  output logic pll1_p_sync_sys_rst_n,
  output logic pll1_q_sync_sys_rst_n,
  output logic pll2_p_sync_sys_rst_n,
  output logic hse_sync_sys_rst_n,
  output logic hsi_ker_sync_sys_rst_n,
  output logic lsi_sync_sys_rst_n,
  output logic per_sync_sys_rst_n
);

  logic css_fail_rst_n;

  // **********************************************************************
  // clock security failure on sys_clk
  // **********************************************************************
  // failure asserts at once, clears two sys_clk edges after it drops
  rcc_reset_sync u_css_rst_sync (
    .clk      (sys_clk),
    .src_rst_n(~hsecss_fail),
    .gen_rst_n(css_fail_rst_n)
  );

  assign css_fail_rst = ~css_fail_rst_n;

  // **********************************************************************
  // system reset release per kernel domain
  // **********************************************************************
  rcc_reset_sync u_pll1_p_rst_sync (
    .clk      (pll1_p_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(pll1_p_sync_sys_rst_n)
  );

  rcc_reset_sync u_pll1_q_rst_sync (
    .clk      (pll1_q_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(pll1_q_sync_sys_rst_n)
  );

  rcc_reset_sync u_pll2_p_rst_sync (
    .clk      (pll2_p_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(pll2_p_sync_sys_rst_n)
  );

  rcc_reset_sync u_hse_rst_sync (
    .clk      (hse_origin_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(hse_sync_sys_rst_n)
  );

  rcc_reset_sync u_hsi_ker_rst_sync (
    .clk      (hsi_origin_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(hsi_ker_sync_sys_rst_n)
  );

  rcc_reset_sync u_lsi_rst_sync (
    .clk      (lsi_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(lsi_sync_sys_rst_n)
  );

  // peripheral domain, also feeds the peripheral reset generator
  rcc_reset_sync u_per_rst_sync (
    .clk      (per_clk),
    .src_rst_n(sys_rst_n),
    .gen_rst_n(per_sync_sys_rst_n)
  );

endmodule

// ==== hw/rcc_sys_clk_ctrl.sv ====
// system clock source switch FSM
// waits for the target ready bit with a timeout
// falls back to HSI on a clock security failure

`timescale 1ns/100ps

module rcc_sys_clk_ctrl (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  logic                 sw_req,
  input  rcc_pkg::sysclk_src_t sw_src,
  input  logic                 hsi_rdy,
  input  logic                 hse_rdy,
  input  logic                 pll1_rdy,
  input  logic                 csi_rdy,
  input  logic                 css_fail_rst,
  input  logic                 css_flag,
  output rcc_pkg::sysclk_src_t sysclk_sws,
  output logic                 css_evt,
  output logic                 sw_err_evt
);

  import rcc_pkg::*;

  sw_state_t            state;
  sysclk_src_t          target;
  logic [TMO_CNT_W-1:0] tmo_cnt;
  logic                 css_fail_q;
  logic                 tgt_rdy;
  logic                 req_blocked;

  // ready bit of the requested source
  always_comb begin
    case (target)
      HSI:     tgt_rdy = hsi_rdy;
      HSE:     tgt_rdy = hse_rdy;
      PLL1:    tgt_rdy = pll1_rdy;
      default: tgt_rdy = csi_rdy;
    endcase
  end

  // HSE stays off limits until software clears the failure flag
  assign req_blocked = (sw_src == HSE) && css_flag;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      state      <= RUN;
      target     <= HSI;
      sysclk_sws <= HSI;
      tmo_cnt    <= '0;
      css_fail_q <= 1'b0;
      css_evt    <= 1'b0;
      sw_err_evt <= 1'b0;
    end else begin
      css_fail_q <= css_fail_rst;
      css_evt    <= css_fail_rst && !css_fail_q;
      sw_err_evt <= 1'b0;
      if (css_fail_rst) begin
        // failure overrides any switch in flight
        state      <= CSS_HOLD;
        sysclk_sws <= HSI;
      end else begin
        case (state)
          RUN, CSS_HOLD: begin
            if (sw_req && req_blocked) begin
              sw_err_evt <= 1'b1;
            end else if (sw_req) begin
              target  <= sw_src;
              tmo_cnt <= '0;
              state   <= WAIT_RDY;
            end else if (state == CSS_HOLD && !css_flag) begin
              state <= RUN;
            end
          end
          WAIT_RDY: begin
            if (tgt_rdy) begin
              sysclk_sws <= target;
              state      <= SWITCH;
            end else if (tmo_cnt == TMO_CNT_W'(SWITCH_TIMEOUT - 1)) begin
              sw_err_evt <= 1'b1;
              state      <= RUN;
            end else begin
              tmo_cnt <= tmo_cnt + 1'b1;
            end
          end
          // one settle cycle after the handover
          SWITCH:  state <= RUN;
          default: state <= RUN;
        endcase
      end
    end
  end

  a_no_hse_in_hold: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (state == CSS_HOLD) |-> (sysclk_sws != HSE)
  ) else $error("sysclk_sws is HSE during CSS_HOLD");

endmodule

// ==== hw/rcc_top.sv ====
// top level of the reset and clock control block
// register bank, system clock FSM, reset synchronizer bank, peripheral resets

`timescale 1ns/100ps

module rcc_top (
  // clocks
  input  logic                  sys_clk,
  input  logic                  pll1_p_clk,
  input  logic                  pll1_q_clk,
  input  logic                  pll2_p_clk,
  input  logic                  hse_origin_clk,
  input  logic                  hsi_origin_clk,
  input  logic                  lsi_clk,
  input  logic                  per_clk,
  // reset and security
  input  logic                  rst_n,
  input  logic                  hsecss_fail,
  // oscillator ready
  input  logic                  hsi_rdy,
  input  logic                  hse_rdy,
  input  logic                  pll1_rdy,
  input  logic                  csi_rdy,
  // register access
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  rcc_pkg::rcc_addr_t    addr,
  input  rcc_pkg::rcc_data_t    wdata,
  output rcc_pkg::rcc_data_t    rdata,
  // resets
  output logic                  pll1_p_sync_sys_rst_n,
  output logic                  pll1_q_sync_sys_rst_n,
  output logic                  pll2_p_sync_sys_rst_n,
  output logic                  hse_sync_sys_rst_n,
  output logic                  hsi_ker_sync_sys_rst_n,
  output logic                  lsi_sync_sys_rst_n,
  output logic                  per_sync_sys_rst_n,
  output logic                  css_fail_rst,
  output rcc_pkg::periph_mask_t per_rst_n
);

  import rcc_pkg::*;

  logic         sw_req;
  sysclk_src_t  sw_src;
  sysclk_src_t  sysclk_sws;
  logic         css_evt;
  logic         sw_err_evt;
  logic         css_flag;
  periph_mask_t sw_rst;

  rcc_regs u_regs (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .rd_en     (rd_en),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata),
    .sysclk_sws(sysclk_sws),
    .css_evt   (css_evt),
    .sw_err_evt(sw_err_evt),
    .sw_req    (sw_req),
    .sw_src    (sw_src),
    .css_flag  (css_flag),
    .sw_rst    (sw_rst)
  );

  rcc_sys_clk_ctrl u_sys_clk_ctrl (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .sw_req      (sw_req),
    .sw_src      (sw_src),
    .hsi_rdy     (hsi_rdy),
    .hse_rdy     (hse_rdy),
    .pll1_rdy    (pll1_rdy),
    .csi_rdy     (csi_rdy),
    .css_fail_rst(css_fail_rst),
    .css_flag    (css_flag),
    .sysclk_sws  (sysclk_sws),
    .css_evt     (css_evt),
    .sw_err_evt  (sw_err_evt)
  );

  // top-level rst_n is the system reset source for every domain
  rcc_rst_sync u_rst_sync (
    .sys_clk               (sys_clk),
    .pll1_p_clk            (pll1_p_clk),
    .pll1_q_clk            (pll1_q_clk),
    .pll2_p_clk            (pll2_p_clk),
    .hse_origin_clk        (hse_origin_clk),
    .hsi_origin_clk        (hsi_origin_clk),
    .lsi_clk               (lsi_clk),
    .per_clk               (per_clk),
    .sys_rst_n             (rst_n),
    .hsecss_fail           (hsecss_fail),
    .css_fail_rst          (css_fail_rst),
    .pll1_p_sync_sys_rst_n (pll1_p_sync_sys_rst_n),
    .pll1_q_sync_sys_rst_n (pll1_q_sync_sys_rst_n),
    .pll2_p_sync_sys_rst_n (pll2_p_sync_sys_rst_n),
    .hse_sync_sys_rst_n    (hse_sync_sys_rst_n),
    .hsi_ker_sync_sys_rst_n(hsi_ker_sync_sys_rst_n),
    .lsi_sync_sys_rst_n    (lsi_sync_sys_rst_n),
    .per_sync_sys_rst_n    (per_sync_sys_rst_n)
  );

  rcc_periph_rst u_periph_rst (
    .per_clk       (per_clk),
    .per_sync_rst_n(per_sync_sys_rst_n),
    .sw_rst        (sw_rst),
    .per_rst_n     (per_rst_n)
  );

endmodule

// ==== tests/rcc_tb.sv ====
// testbench for the reset and clock control block
// clock generators, register access tasks and a stimulus table
// checks for reset release, clock switching, security failure and peripheral resets

`timescale 1ns/100ps

module rcc_tb;

  import rcc_pkg::*;

  localparam int NUM_DOM    = 7;
  localparam int POLL_LIMIT = 40;
  localparam int WAIT_LIMIT = 40;
  localparam int PER_DOM    = 6;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_SWITCH,
    OP_CSS,
    OP_PRST
  } op_t;

  // ready bits are {csi, pll1, hse, hsi}
  typedef struct packed {
    op_t        op;
    rcc_addr_t  addr;
    rcc_data_t  data;
    logic [3:0] rdy;
    rcc_data_t  exp_val;
  } step_t;

  logic         sys_clk;
  logic         pll1_p_clk;
  logic         pll1_q_clk;
  logic         pll2_p_clk;
  logic         hse_origin_clk;
  logic         hsi_origin_clk;
  logic         lsi_clk;
  logic         per_clk;
  logic         rst_n;
  logic         hsecss_fail;
  logic         hsi_rdy;
  logic         hse_rdy;
  logic         pll1_rdy;
  logic         csi_rdy;
  logic         wr_en;
  logic         rd_en;
  rcc_addr_t    addr;
  rcc_data_t    wdata;
  rcc_data_t    rdata;
  logic         css_fail_rst;
  periph_mask_t per_rst_n;

  // domain order: pll1_p, pll1_q, pll2_p, hse, hsi_ker, lsi, per
  logic [NUM_DOM-1:0] dom_rst;
  logic [NUM_DOM-1:0] dom_clk;
  int                 edge_cnt [NUM_DOM];
  int                 rise_cnt [NUM_DOM];

  step_t  steps [$];
  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;

  rcc_top DUT (
    .sys_clk               (sys_clk),
    .pll1_p_clk            (pll1_p_clk),
    .pll1_q_clk            (pll1_q_clk),
    .pll2_p_clk            (pll2_p_clk),
    .hse_origin_clk        (hse_origin_clk),
    .hsi_origin_clk        (hsi_origin_clk),
    .lsi_clk               (lsi_clk),
    .per_clk               (per_clk),
    .rst_n                 (rst_n),
    .hsecss_fail           (hsecss_fail),
    .hsi_rdy               (hsi_rdy),
    .hse_rdy               (hse_rdy),
    .pll1_rdy              (pll1_rdy),
    .csi_rdy               (csi_rdy),
    .wr_en                 (wr_en),
    .rd_en                 (rd_en),
    .addr                  (addr),
    .wdata                 (wdata),
    .rdata                 (rdata),
    .pll1_p_sync_sys_rst_n (dom_rst[0]),
    .pll1_q_sync_sys_rst_n (dom_rst[1]),
    .pll2_p_sync_sys_rst_n (dom_rst[2]),
    .hse_sync_sys_rst_n    (dom_rst[3]),
    .hsi_ker_sync_sys_rst_n(dom_rst[4]),
    .lsi_sync_sys_rst_n    (dom_rst[5]),
    .per_sync_sys_rst_n    (dom_rst[6]),
    .css_fail_rst          (css_fail_rst),
    .per_rst_n             (per_rst_n)
  );

  // **********************************************************************
  // clocks
  // **********************************************************************
  // no kernel clock edge lands on a falling sys_clk edge
  initial begin
    sys_clk = 1'b1;
    forever #2 sys_clk = ~sys_clk;
  end
  initial begin
    hsi_origin_clk = 1'b0;
    forever #1.5 hsi_origin_clk = ~hsi_origin_clk;
  end
  initial begin
    per_clk = 1'b0;
    forever #2.5 per_clk = ~per_clk;
  end
  initial begin
    pll1_p_clk = 1'b0;
    forever #3 pll1_p_clk = ~pll1_p_clk;
  end
  initial begin
    hse_origin_clk = 1'b0;
    forever #4.5 hse_origin_clk = ~hse_origin_clk;
  end
  initial begin
    pll1_q_clk = 1'b0;
    forever #5 pll1_q_clk = ~pll1_q_clk;
  end
  initial begin
    pll2_p_clk = 1'b0;
    forever #7 pll2_p_clk = ~pll2_p_clk;
  end
  initial begin
    lsi_clk = 1'b0;
    forever #15 lsi_clk = ~lsi_clk;
  end

  assign dom_clk = {per_clk, lsi_clk, hsi_origin_clk, hse_origin_clk,
                    pll2_p_clk, pll1_q_clk, pll1_p_clk};

  // edge count of each domain clock, captured when its reset releases
  for (genvar d = 0; d < NUM_DOM; d++) begin : g_dom
    always @(posedge dom_clk[d]) edge_cnt[d] = edge_cnt[d] + 1;
    always @(posedge dom_rst[d]) rise_cnt[d] = edge_cnt[d];
  end

  // **********************************************************************
  // reporting
  // **********************************************************************
  task automatic log_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0.1f ns: %s", $realtime, msg);
  endtask

  task automatic fail_check(input string msg);
    errors++;
    $display("ERROR at %0.1f ns: %s", $realtime, msg);
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  function automatic string op_label(input op_t op);
    case (op)
      OP_WRITE:  return "write";
      OP_READ:   return "read";
      OP_SWITCH: return "clock switch";
      OP_CSS:    return "security failure";
      default:   return "peripheral reset";
    endcase
  endfunction

  // **********************************************************************
  // register access, all driven on the falling sys_clk edge
  // **********************************************************************
  task automatic write_reg(input rcc_addr_t a, input rcc_data_t d);
    @(negedge sys_clk);
    wr_en = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge sys_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_reg(input rcc_addr_t a, output rcc_data_t d);
    @(negedge sys_clk);
    rd_en = 1'b1;
    addr  = a;
    @(negedge sys_clk);
    rd_en = 1'b0;
    d = rdata;
  endtask

  task automatic check_read(input rcc_addr_t a, input rcc_data_t exp_val);
    rcc_data_t got;
    read_reg(a, got);
    if (got !== exp_val) begin
      log_mismatch($sformatf("register %0d read 0x%02h, expected 0x%02h", a, got, exp_val));
    end
  endtask

  task automatic drive_ready(input logic [3:0] r);
    {csi_rdy, pll1_rdy, hse_rdy, hsi_rdy} = r;
  endtask

  // **********************************************************************
  // scenario tasks
  // **********************************************************************
  task automatic reset_and_release();
    int base [NUM_DOM];
    int waits;
    rst_n = 1'b0;
    #0.1;
    if (dom_rst !== '0) begin
      log_mismatch($sformatf("domain resets 0x%02h did not drop with rst_n", dom_rst));
    end
    repeat (3) @(negedge sys_clk);
    if (dom_rst !== '0 || per_rst_n !== '0) begin
      log_mismatch("reset outputs not all low while rst_n is low");
    end
    rst_n = 1'b1;
    for (int d = 0; d < NUM_DOM; d++) begin
      base[d] = edge_cnt[d];
    end
    waits = 0;
    while (dom_rst !== '1 && waits < WAIT_LIMIT) begin
      @(negedge sys_clk);
      waits++;
    end
    if (dom_rst !== '1) begin
      fail_check("timeout: domain resets never released");
    end else begin
      for (int d = 0; d < NUM_DOM; d++) begin
        if (rise_cnt[d] <= base[d] || rise_cnt[d] - base[d] > RST_SYNC_STAGES + 1) begin
          log_mismatch($sformatf("domain %0d released after %0d edges", d,
                                 rise_cnt[d] - base[d]));
        end
      end
    end
  endtask

  task automatic switch_clock(input sysclk_src_t src, input logic [3:0] rdy,
                              input sysclk_src_t exp_src);
    rcc_data_t   cfgr;
    rcc_data_t   sr;
    sysclk_src_t start_src;
    int          delay;
    int          polls;
    logic        done;
    read_reg(ADDR_CFGR, cfgr);
    start_src = sysclk_src_t'(cfgr[3:2]);
    // target ready bit comes up after a random number of polls
    delay = $random(seed) & 7;
    drive_ready(rdy & ~(4'b0001 << src));
    write_reg(ADDR_CFGR, rcc_data_t'(src));
    done  = 1'b0;
    polls = 0;
    while (!done && polls < POLL_LIMIT) begin
      if (polls == delay) begin
        drive_ready(rdy);
      end
      read_reg(ADDR_CFGR, cfgr);
      if (cfgr[3:2] != start_src) begin
        done = 1'b1;
      end else if (exp_src == start_src) begin
        // a refused or abandoned switch ends with sw_err
        read_reg(ADDR_SR, sr);
        if (sr[1]) begin
          done = 1'b1;
        end
      end
      polls++;
    end
    if (!done) begin
      fail_check($sformatf("timeout: switch to source %0d never finished", src));
    end else if (cfgr[3:2] !== exp_src) begin
      log_mismatch($sformatf("sysclk_sws is %0d, expected %0d", cfgr[3:2], exp_src));
    end
  endtask

  task automatic pulse_css();
    int waits;
    @(negedge sys_clk);
    hsecss_fail = 1'b1;
    #0.1;
    if (css_fail_rst !== 1'b1) begin
      log_mismatch("css_fail_rst did not rise with hsecss_fail");
    end
    repeat (3) @(negedge sys_clk);
    hsecss_fail = 1'b0;
    waits = 0;
    while (css_fail_rst !== 1'b0 && waits < WAIT_LIMIT) begin
      @(negedge sys_clk);
      waits++;
    end
    if (css_fail_rst !== 1'b0) begin
      fail_check("timeout: css_fail_rst stayed high after hsecss_fail dropped");
    end else if (waits != 2) begin
      log_mismatch($sformatf("css_fail_rst fell after %0d sys_clk edges, expected 2", waits));
    end
  endtask

  task automatic exercise_periph_rst(input int idx);
    periph_mask_t mask;
    int           waits;
    int           fall_edge;
    mask = periph_mask_t'(1) << idx;
    write_reg(ADDR_RSTR, rcc_data_t'(mask));
    waits = 0;
    while (per_rst_n[idx] !== 1'b0 && waits < 10) begin
      @(negedge per_clk);
      waits++;
    end
    if (per_rst_n[idx] !== 1'b0) begin
      fail_check($sformatf("timeout: per_rst_n[%0d] never fell", idx));
    end else begin
      fall_edge = edge_cnt[PER_DOM];
      if (per_rst_n !== ~mask) begin
        log_mismatch($sformatf("per_rst_n is 0x%01h, expected 0x%01h", per_rst_n, ~mask));
      end
      write_reg(ADDR_RSTR, 8'h00);
      waits = 0;
      while (per_rst_n[idx] !== 1'b1 && waits < WAIT_LIMIT) begin
        @(negedge per_clk);
        waits++;
      end
      if (per_rst_n[idx] !== 1'b1) begin
        fail_check($sformatf("timeout: per_rst_n[%0d] never rose", idx));
      end else if (edge_cnt[PER_DOM] - fall_edge < RST_PULSE_CYCLES) begin
        log_mismatch($sformatf("per_rst_n[%0d] low for only %0d cycles", idx,
                               edge_cnt[PER_DOM] - fall_edge));
      end
    end
  endtask

  // **********************************************************************
  // stimulus table
  // **********************************************************************
  function automatic void add_step(input op_t op, input rcc_addr_t a, input rcc_data_t d,
                                   input logic [3:0] r, input rcc_data_t e);
    steps.push_back(step_t'{op, a, d, r, e});
  endfunction

  task automatic load_table();
    // register access
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b0001, 8'h00);
    add_step(OP_WRITE,  ADDR_RSTR, 8'h0a, 4'b0001, 8'h00);
    add_step(OP_READ,   ADDR_RSTR, 8'h00, 4'b0001, 8'h0a);
    add_step(OP_WRITE,  ADDR_RSTR, 8'h00, 4'b0001, 8'h00);
    add_step(OP_READ,   ADDR_RSTR, 8'h00, 4'b0001, 8'h00);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b0001, 8'h00);
    // clock switches, HSE never ready in the third
    add_step(OP_SWITCH, ADDR_CFGR, 8'h02, 4'b0101, 8'h02);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b0101, 8'h0a);
    add_step(OP_SWITCH, ADDR_CFGR, 8'h03, 4'b1101, 8'h03);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1101, 8'h0f);
    add_step(OP_SWITCH, ADDR_CFGR, 8'h01, 4'b1101, 8'h03);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1101, 8'h0d);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b1101, 8'h02);
    add_step(OP_WRITE,  ADDR_SR,   8'h02, 4'b1101, 8'h00);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b1101, 8'h00);
    add_step(OP_SWITCH, ADDR_CFGR, 8'h01, 4'b1111, 8'h01);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1111, 8'h05);
    add_step(OP_SWITCH, ADDR_CFGR, 8'h02, 4'b1111, 8'h02);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1111, 8'h0a);
    // security failure, HSE refused until css_flag clears
    add_step(OP_CSS,    ADDR_SR,   8'h00, 4'b1111, 8'h00);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1111, 8'h02);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b1111, 8'h01);
    add_step(OP_SWITCH, ADDR_CFGR, 8'h01, 4'b1111, 8'h00);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b1111, 8'h03);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1111, 8'h01);
    add_step(OP_WRITE,  ADDR_SR,   8'h01, 4'b1111, 8'h00);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b1111, 8'h02);
    add_step(OP_WRITE,  ADDR_SR,   8'h02, 4'b1111, 8'h00);
    add_step(OP_READ,   ADDR_SR,   8'h00, 4'b1111, 8'h00);
    add_step(OP_SWITCH, ADDR_CFGR, 8'h01, 4'b1111, 8'h01);
    add_step(OP_READ,   ADDR_CFGR, 8'h00, 4'b1111, 8'h05);
    // peripheral resets, data is the peripheral index
    for (int i = 0; i < NUM_PERIPH; i++) begin
      add_step(OP_PRST, ADDR_RSTR, rcc_data_t'(i), 4'b1111, 8'h00);
    end
    add_step(OP_READ,   ADDR_RSTR, 8'h00, 4'b1111, 8'h00);
  endtask

  // **********************************************************************
  // main sequence
  // **********************************************************************
  initial begin
    step_t s;
    int    errors_before;
    seed         = 56717;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b1;
    hsecss_fail  = 1'b0;
    wr_en        = 1'b0;
    rd_en        = 1'b0;
    addr         = '0;
    wdata        = '0;
    drive_ready(4'b0001);
    load_table();

    @(negedge sys_clk);
    errors_before = errors;
    reset_and_release();
    close_test("reset release", errors_before);

    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      errors_before = errors;
      case (s.op)
        OP_WRITE:  write_reg(s.addr, s.data);
        OP_READ:   check_read(s.addr, s.exp_val);
        OP_SWITCH: switch_clock(sysclk_src_t'(s.data[1:0]), s.rdy,
                                sysclk_src_t'(s.exp_val[1:0]));
        OP_CSS:    pulse_css();
        default:   exercise_periph_rst(s.data);
      endcase
      close_test($sformatf("step %0d %s", i, op_label(s.op)), errors_before);
    end

    // reset dropped in the middle of the run
    @(negedge sys_clk);
    errors_before = errors;
    reset_and_release();
    close_test("mid-run reset", errors_before);

    $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
